//--- cmd_dispatch.sv
`timescale 1ns/1ps
//----------------------------------------
// command dispatch
// decodes each command, holds the scope
// settings and requests the reply
//----------------------------------------
module cmd_dispatch (
	input  logic                   clk,
	input  logic                   rstn,
	input  scope_pkg::cmd_t        i_cmd,
	input  logic                   i_cmd_valid,
	input  logic                   i_reply_done,
	input  logic [7:0]             i_board_in,
	input  scope_pkg::count_t      i_event_count,
	input  scope_pkg::count_t      i_post_count,
	input  scope_pkg::ram_addr_t   i_trig_addr,
	output logic                   o_done,
	output logic                   o_word_req,
	output logic [31:0]            o_word,
	output logic                   o_burst_req,
	output scope_pkg::ram_addr_t   o_rd_start,
	output scope_pkg::len_t        o_rd_len,
	output scope_pkg::trig_cfg_t   o_cfg,
	output logic                   o_arm,
	output logic                   o_readout_done,
	output logic [7:0]             o_board_out
);

	scope_pkg::ram_addr_t pre_offset;    // samples shown before trigger
	logic                 read_busy;     // burst reply in flight
	logic [7:0]           board_next;
	logic [31:0]          reply_word;
	logic [11:0]          th_b1;
	logic [11:0]          th_b2;
	scope_pkg::sample_t   lo_th;
	scope_pkg::sample_t   hi_th;

	//----------------------------------------
	// thresholds from level b1 and hysteresis b2
	assign th_b1 = {4'd0, i_cmd.b1};
	assign th_b2 = {4'd0, i_cmd.b2};
	assign lo_th = ((th_b1 - th_b2 - 12'(scope_pkg::THRESH_CENTER)) << scope_pkg::THRESH_SHIFT)
		+ 12'(scope_pkg::THRESH_BIAS);
	assign hi_th = ((th_b1 + th_b2 - 12'(scope_pkg::THRESH_CENTER)) << scope_pkg::THRESH_SHIFT)
		+ 12'(scope_pkg::THRESH_BIAS);

	always_comb begin
		board_next = o_board_out;
		board_next[i_cmd.b1[2:0]] = i_cmd.b2[0];    // one bit per command
	end

	always_comb begin
		reply_word = '0;
		case (i_cmd.op)
			scope_pkg::OP_ARM:   reply_word = {i_event_count, i_post_count};
			scope_pkg::OP_INFO: begin
				if (i_cmd.b1 == 8'd0)      reply_word = 32'(scope_pkg::FW_VERSION);
				else if (i_cmd.b1 == 8'd1) reply_word = {4{i_board_in}};
			end
			scope_pkg::OP_TRIG:  reply_word = 32'(scope_pkg::OP_TRIG);   // echo opcode
			scope_pkg::OP_BOARD: reply_word = {24'd0, board_next};
			default: ;
		endcase
	end

	//----------------------------------------
	// settings and request pulses
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_cfg <= '{lower_th: '0, upper_th: '0, tot: '0,
				trig_type: scope_pkg::TRIG_NONE, post_len: '0};
			pre_offset     <= '0;
			o_board_out    <= '0;
			read_busy      <= 1'b0;
			o_done         <= 1'b0;
			o_word_req     <= 1'b0;
			o_burst_req    <= 1'b0;
			o_arm          <= 1'b0;
			o_readout_done <= 1'b0;
		end else begin
			o_done         <= 1'b0;
			o_word_req     <= 1'b0;
			o_burst_req    <= 1'b0;
			o_arm          <= 1'b0;
			o_readout_done <= 1'b0;
			if (i_cmd_valid) begin
				case (i_cmd.op)
					scope_pkg::OP_READ: begin
						o_burst_req <= 1'b1;
						read_busy   <= 1'b1;
					end
					scope_pkg::OP_ARM: begin
						o_cfg.trig_type <= i_cmd.b1;
						o_cfg.post_len  <= {i_cmd.b5, i_cmd.b4};
						o_arm           <= 1'b1;    // fsm drops it unless ready
						o_word_req      <= 1'b1;
					end
					scope_pkg::OP_INFO: o_word_req <= 1'b1;
					scope_pkg::OP_TRIG: begin
						o_cfg.lower_th <= lo_th;
						o_cfg.upper_th <= hi_th;
						o_cfg.tot      <= i_cmd.b5;
						pre_offset     <= {i_cmd.b3[1:0], i_cmd.b4};
						o_word_req     <= 1'b1;
					end
					scope_pkg::OP_BOARD: begin
						o_board_out <= board_next;
						o_word_req  <= 1'b1;
					end
					default: o_done <= 1'b1;           // unknown, reopen at once
				endcase
			end
			if (i_reply_done) begin
				o_done <= 1'b1;
				if (read_busy) begin
					o_readout_done <= 1'b1;           // frees the held capture
					read_busy      <= 1'b0;
				end
			end
		end
	end

	// reply payload, start wraps around the ring
	always_ff @(posedge clk) begin
		if (i_cmd_valid) begin
			o_word     <= reply_word;
			o_rd_start <= i_trig_addr - pre_offset;
			o_rd_len   <= {i_cmd.b5, i_cmd.b4};
		end
	end

endmodule

//--- cmd_receiver.sv
`timescale 1ns/1ps
//----------------------------------------
// command receiver
// collects eight stream bytes into one
// command and waits for it to be served
//----------------------------------------
module cmd_receiver (
	input  logic              clk,
	input  logic              rstn,
	input  logic              i_tvalid,
	input  logic [7:0]        i_tdata,
	input  logic              i_done,
	output logic              o_tready,
	output scope_pkg::cmd_t   o_cmd,
	output logic              o_cmd_valid
);

	logic [$clog2(scope_pkg::CMD_BYTES)-1:0] byte_cnt;   // bytes taken so far
	logic                                    rx_open;    // idle, taking bytes
	logic                                    take;

	assign take     = i_tvalid && rx_open;
	assign o_tready = rx_open;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt    <= '0;
			rx_open     <= 1'b1;
			o_cmd_valid <= 1'b0;
		end else begin
			o_cmd_valid <= 1'b0;
			if (take) begin
				if (int'(byte_cnt) == scope_pkg::CMD_BYTES - 1) begin
					byte_cnt    <= '0;
					rx_open     <= 1'b0;       // closed until served
					o_cmd_valid <= 1'b1;
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end else if (i_done) begin
				rx_open <= 1'b1;
			end
		end
	end

	// shift in from the top, first byte ends at op
	always_ff @(posedge clk) begin
		if (take) o_cmd <= {i_tdata, o_cmd[63:8]};
	end

endmodule

//--- list.f
+incdir+.
scope_pkg.sv
cmd_receiver.sv
cmd_dispatch.sv
trigger_fsm.sv
sample_ram.sv
reply_streamer.sv
scope_top.sv
tb_scope_top.sv

//--- reply_streamer.sv
`timescale 1ns/1ps
//----------------------------------------
// reply framing
// puts one reply word or a burst of sample
// pairs on the 32-bit stream, keep and last
// from the remaining byte count
//----------------------------------------
module reply_streamer (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   i_word_req,
	input  logic [31:0]            i_word,
	input  logic                   i_burst_req,
	input  scope_pkg::ram_addr_t   i_rd_start,
	input  scope_pkg::len_t        i_rd_len,
	input  scope_pkg::sample_t     i_rd_data,
	input  logic                   i_tready,
	output scope_pkg::ram_addr_t   o_rd_addr,
	output logic                   o_tvalid,
	output logic [31:0]            o_tdata,
	output logic [3:0]             o_tkeep,
	output logic                   o_tlast,
	output logic                   o_reply_done
);

	typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_LO, ST_SEND} tx_state_e;

	tx_state_e            state;
	scope_pkg::ram_addr_t rd_ptr;       // next read address
	scope_pkg::len_t      remain;       // bytes left incl. current word
	logic                 word_mode;    // single reply word
	logic                 hi_vld;       // upper sample latched
	logic [31:0]          word_q;
	scope_pkg::sample_t   lo_q;
	scope_pkg::sample_t   hi_q;
	scope_pkg::sample_t   hi_now;

	assign o_rd_addr = (state == ST_IDLE) ? i_rd_start : rd_ptr;
	assign hi_now    = hi_vld ? hi_q : i_rd_data;      // ram data on first send cycle
	assign o_tdata   = word_mode ? word_q : {4'd0, hi_now, 4'd0, lo_q};
	assign o_tlast   = (remain <= 16'd4);
	assign o_tkeep   = (remain >= 16'd4) ? 4'b1111 : (4'b0001 << remain[1:0]) - 4'b0001;

	//----------------------------------------
	// two ram reads per burst word
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state        <= ST_IDLE;
			rd_ptr       <= '0;
			remain       <= '0;
			word_mode    <= 1'b0;
			hi_vld       <= 1'b0;
			o_tvalid     <= 1'b0;
			o_reply_done <= 1'b0;
		end else begin
			o_reply_done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_word_req) begin
						remain    <= 16'd4;
						word_mode <= 1'b1;
						o_tvalid  <= 1'b1;
						state     <= ST_SEND;
					end else if (i_burst_req) begin
						remain    <= i_rd_len;
						word_mode <= 1'b0;
						rd_ptr    <= i_rd_start + 1'b1;   // start read already issued
						state     <= ST_LO;
					end
				end
				ST_FETCH: begin
					rd_ptr <= rd_ptr + 1'b1;
					state  <= ST_LO;
				end
				ST_LO: begin
					o_tvalid <= 1'b1;
					state    <= ST_SEND;
				end
				ST_SEND: begin
					hi_vld <= 1'b1;                       // hold under back-pressure
					if (i_tready) begin
						o_tvalid <= 1'b0;
						hi_vld   <= 1'b0;
						if (o_tlast) begin
							o_reply_done <= 1'b1;
							state        <= ST_IDLE;
						end else begin
							remain <= remain - 16'd4;
							rd_ptr <= rd_ptr + 1'b1;      // wraps with the ring
							state  <= ST_FETCH;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && i_word_req) word_q <= i_word;
		if (state == ST_LO)   lo_q <= i_rd_data;      // first sample of the pair
		if (state == ST_SEND) hi_q <= hi_now;
	end

endmodule

//--- sample_ram.sv
`timescale 1ns/1ps
//----------------------------------------
// sample ring buffer
// one write port, one registered read
//----------------------------------------
module sample_ram (
	input  logic                   clk,
	input  logic                   i_wr_en,
	input  scope_pkg::ram_addr_t   i_wr_addr,
	input  scope_pkg::sample_t     i_wr_data,
	input  scope_pkg::ram_addr_t   i_rd_addr,
	output scope_pkg::sample_t     o_rd_data
);

	scope_pkg::sample_t mem [scope_pkg::RAM_DEPTH];

	always_ff @(posedge clk) begin
		if (i_wr_en) mem[i_wr_addr] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr];                  // one cycle latency
	end

endmodule

//--- scope_pkg.sv
//----------------------------------------
// scope package
// widths, opcodes, trigger constants and
// the types shared by the command path
//----------------------------------------
package scope_pkg;

	//----------------------------------------
	// command framing and opcodes
	localparam int         CMD_BYTES = 8;        // bytes per command
	localparam logic [7:0] OP_READ   = 8'd0;     // buffer readout
	localparam logic [7:0] OP_ARM    = 8'd1;     // arm and status
	localparam logic [7:0] OP_INFO   = 8'd2;     // version, board inputs
	localparam logic [7:0] OP_TRIG   = 8'd8;     // trigger settings
	localparam logic [7:0] OP_BOARD  = 8'd10;    // board output bit

	// trigger types, as sent in the arm command
	localparam logic [7:0] TRIG_NONE = 8'd0;     // immediate
	localparam logic [7:0] TRIG_FALL = 8'd1;
	localparam logic [7:0] TRIG_RISE = 8'd2;

	localparam int FW_VERSION    = 17;
	localparam int THRESH_CENTER = 128;          // midscale of the 8-bit level
	localparam int THRESH_SHIFT  = 4;            // 8-bit level to 12-bit sample
	localparam int THRESH_BIAS   = 8;            // half step of the shifted level
	localparam int RAM_DEPTH     = 1024;

	//----------------------------------------
	// types
	typedef logic signed [11:0] sample_t;       // adc sample
	typedef logic [9:0]         ram_addr_t;     // ring buffer address
	typedef logic [15:0]        len_t;          // post length, readout bytes
	typedef logic [15:0]        count_t;        // event and post counts

	// first byte received lands in op
	typedef struct packed {
		logic [7:0] b7;
		logic [7:0] b6;
		logic [7:0] b5;
		logic [7:0] b4;
		logic [7:0] b3;
		logic [7:0] b2;
		logic [7:0] b1;
		logic [7:0] op;
	} cmd_t;

	typedef struct packed {
		sample_t    lower_th;
		sample_t    upper_th;
		logic [7:0] tot;                         // time over threshold
		logic [7:0] trig_type;
		len_t       post_len;                    // samples kept after trigger
	} trig_cfg_t;

	typedef enum logic [2:0] {
		ACQ_READY,
		ACQ_FALL_ARM,
		ACQ_FALL_WAIT,
		ACQ_RISE_ARM,
		ACQ_RISE_WAIT,
		ACQ_POST,
		ACQ_HOLD
	} acq_state_e;

endpackage

//--- scope_top.sv
`timescale 1ns/1ps
//----------------------------------------
// scope command path top
// receiver, dispatch, acquisition, ring
// buffer and reply framing
//----------------------------------------
module scope_top (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 i_tvalid,     // command bytes in
	output logic                 o_tready,
	input  logic [7:0]           i_tdata,
	output logic                 o_tvalid,     // reply words out
	input  logic                 i_tready,
	output logic [31:0]          o_tdata,
	output logic [3:0]           o_tkeep,
	output logic                 o_tlast,
	input  scope_pkg::sample_t   i_sample,
	input  logic [7:0]           i_board_in,
	output logic [7:0]           o_board_out
);

	scope_pkg::cmd_t      cmd;
	logic                 cmd_valid;
	logic                 cmd_done;
	logic                 word_req;
	logic [31:0]          word;
	logic                 burst_req;
	scope_pkg::ram_addr_t rd_start;
	scope_pkg::len_t      rd_len;
	logic                 reply_done;
	scope_pkg::trig_cfg_t cfg;
	logic                 arm;
	logic                 readout_done;
	scope_pkg::count_t    event_count;
	scope_pkg::count_t    post_count;
	scope_pkg::ram_addr_t trig_addr;
	logic                 wr_en;
	scope_pkg::ram_addr_t wr_addr;
	scope_pkg::sample_t   wr_data;
	scope_pkg::ram_addr_t rd_addr;
	scope_pkg::sample_t   rd_data;

	cmd_receiver cmd_receiver_i (
		.clk, .rstn, .i_tvalid, .i_tdata, .i_done(cmd_done),
		.o_tready, .o_cmd(cmd), .o_cmd_valid(cmd_valid)
	);

	cmd_dispatch cmd_dispatch_i (
		.clk, .rstn, .i_cmd(cmd), .i_cmd_valid(cmd_valid), .i_reply_done(reply_done),
		.i_board_in, .i_event_count(event_count), .i_post_count(post_count),
		.i_trig_addr(trig_addr), .o_done(cmd_done), .o_word_req(word_req), .o_word(word),
		.o_burst_req(burst_req), .o_rd_start(rd_start), .o_rd_len(rd_len), .o_cfg(cfg),
		.o_arm(arm), .o_readout_done(readout_done), .o_board_out
	);

	trigger_fsm trigger_fsm_i (
		.clk, .rstn, .i_sample, .i_cfg(cfg), .i_arm(arm), .i_readout_done(readout_done),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data), .o_trig_addr(trig_addr),
		.o_event_count(event_count), .o_post_count(post_count)
	);

	sample_ram sample_ram_i (
		.clk, .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
		.i_rd_addr(rd_addr), .o_rd_data(rd_data)
	);

	reply_streamer reply_streamer_i (
		.clk, .rstn, .i_word_req(word_req), .i_word(word), .i_burst_req(burst_req),
		.i_rd_start(rd_start), .i_rd_len(rd_len), .i_rd_data(rd_data), .i_tready,
		.o_rd_addr(rd_addr), .o_tvalid, .o_tdata, .o_tkeep, .o_tlast,
		.o_reply_done(reply_done)
	);

endmodule

//--- tb_scope_tasks.svh
//----------------------------------------
// testbench helpers
// lcg, command send, reply collect and
// the threshold model
//----------------------------------------
`ifndef TB_SCOPE_TASKS_SVH
`define TB_SCOPE_TASKS_SVH

function automatic logic [31:0] lcg_step(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;        // numerical recipes constants
endfunction

// level in 8-bit steps to a 12-bit threshold
function automatic int thresh_model(input int level);
	return ((level - 128) * 16) + 8;
endfunction

function automatic logic [63:0] cmd_word(input logic [7:0] op, input logic [7:0] b1,
	input logic [7:0] b2, input logic [15:0] len);
	return {16'd0, len, 8'd0, b2, b1, op};          // len lands in b5:b4
endfunction

task automatic report_fail(input string why);
	$display("%s", why);
	$display("Testbench failed");
	$fatal(1, "stopped at first error");
endtask

task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
	assert (act === exp) else
		report_fail($sformatf("error: time %0t, %s expected %0h, actual %0h",
			$time, name, exp, act));
endtask

//----------------------------------------
// command and reply
task automatic send_cmd(input logic [63:0] c);
	int n;
	for (int k = 0; k < 8; k++) begin
		@(posedge clk);
		i_tvalid <= 1'b1;
		i_tdata  <= c[8 * k +: 8];                  // opcode first
		n = 0;
		@(negedge clk);
		while (!o_tready) begin
			n++;
			assert (n < TIMEOUT) else report_fail("timeout waiting for command ready");
			@(negedge clk);
		end
	end
	@(posedge clk);                                 // last byte taken here
	i_tvalid <= 1'b0;
	@(negedge clk);
	take_idx = sample_log.size();
endtask

task automatic collect_reply(output int nw);
	int n;
	n = 0;
	while (rx_last.size() == 0 || !rx_last[$]) begin
		@(posedge clk);
		n++;
		assert (n < TIMEOUT) else report_fail("timeout waiting for the last reply word");
	end
	nw = rx_data.size();
endtask

task automatic run_cmd(input logic [63:0] c, output int nw);
	rx_data.delete();
	rx_keep.delete();
	rx_last.delete();
	send_cmd(c);
	collect_reply(nw);
endtask

task automatic ask_word(input logic [63:0] c, output logic [31:0] w);
	int nw;
	run_cmd(c, nw);
	check_equal("reply words", 32'd1, nw);
	check_equal("o_tkeep", 32'hf, rx_keep[0]);
	check_equal("o_tlast", 32'd1, rx_last[0]);
	w = rx_data[0];
endtask

// poll arm until the capture is held
task automatic wait_hold(input logic [7:0] ty, input int len, input int exp_ev);
	logic [31:0] w;
	int          n;
	n = 0;
	w = '0;
	while (w[15:0] != 16'hffff) begin
		n++;
		assert (n < 50) else report_fail("capture never reached hold");
		ask_word(cmd_word(scope_pkg::OP_ARM, ty, 8'd0, 16'(len)), w);
	end
	check_equal("event count", exp_ev, w[31:16]);
endtask

task automatic set_mode(input int m);
	@(negedge clk);
	mode = m;
endtask

// first log position holding the readout run
function automatic int find_run();
	int p;
	bit ok;
	for (p = 0; p + rd_run.size() <= sample_log.size(); p++) begin
		ok = 1'b1;
		for (int i = 0; i < rd_run.size(); i++)
			if (sample_log[p + i] !== rd_run[i]) ok = 1'b0;
		if (ok) return p;
	end
	return -1;
endfunction

`endif

//--- tb_scope_top.sv
`timescale 1ns/1ps
//----------------------------------------
// scope command path testbench
// random samples and back-pressure, with
// commands checked against a local model
//----------------------------------------
module tb_scope_top;

	localparam logic [31:0] SEED    = 32'h9b4c_8524;
	localparam int          TIMEOUT = 2000;            // cycles per wait

	logic               clk;
	logic               rstn;
	logic               i_tvalid;
	logic               o_tready;
	logic [7:0]         i_tdata;
	logic               o_tvalid;
	logic               i_tready;
	logic [31:0]        o_tdata;
	logic [3:0]         o_tkeep;
	logic               o_tlast;
	scope_pkg::sample_t i_sample;
	logic [7:0]         i_board_in;
	logic [7:0]         o_board_out;

	scope_pkg::sample_t sample_log[$];    // every driven sample, in order
	scope_pkg::sample_t rd_run[$];        // samples from one readout
	logic [31:0]        rx_data[$];       // words seen on the reply stream
	logic [3:0]         rx_keep[$];
	logic               rx_last[$];
	logic [31:0]        drv_st;           // lcg state, sample driver
	logic [31:0]        scn_st;           // lcg state, scenario
	int                 mode;             // 0 free, 1 between, 2 above, 3 below
	int                 lo_m;             // model thresholds
	int                 hi_m;
	int                 smp;
	int                 take_idx;         // log index written as the command lands
	logic               held;             // word stalled at last negedge
	logic [31:0]        held_data;

	`include "tb_scope_tasks.svh"

	scope_top scope_top_i (
		.clk, .rstn, .i_tvalid, .o_tready, .i_tdata, .o_tvalid, .i_tready,
		.o_tdata, .o_tkeep, .o_tlast, .i_sample, .i_board_in, .o_board_out
	);

	always #20 clk = ~clk;                            // 40 ns period

	//----------------------------------------
	// sample driver and reply back-pressure
	always @(posedge clk) begin
		drv_st = lcg_step(drv_st);
		case (mode)
			1:       smp = lo_m + int'(drv_st[31:16] % (hi_m - lo_m + 1));
			2:       smp = hi_m + 1 + int'(drv_st[31:16] % 64);
			3:       smp = lo_m - 1 - int'(drv_st[31:16] % 64);
			default: smp = int'($signed(drv_st[31:20]));
		endcase
		i_sample <= scope_pkg::sample_t'(smp);
		sample_log.push_back(scope_pkg::sample_t'(smp));
		drv_st = lcg_step(drv_st);
		i_tready <= (drv_st[31:30] != 2'b00);           // low a quarter of the time
	end

	// stream monitor, sampled mid cycle
	always @(negedge clk) begin
		if (held) begin
			check_equal("o_tvalid", 32'd1, o_tvalid);
			check_equal("o_tdata", held_data, o_tdata); // steady under stall
		end
		if (o_tvalid && i_tready) begin
			rx_data.push_back(o_tdata);
			rx_keep.push_back(o_tkeep);
			rx_last.push_back(o_tlast);
		end
		held      = o_tvalid && !i_tready;
		held_data = o_tdata;
	end

	//----------------------------------------
	// scenario
	initial begin
		logic [31:0] w;
		logic [7:0]  b1;
		logic [7:0]  b2;
		logic [7:0]  board_m;
		int          nw;
		int          len;
		int          t0;
		int          ev;
		int          r;
		clk        = 1'b0;
		rstn       = 1'b0;
		i_tvalid   = 1'b0;
		i_tdata    = '0;
		i_tready   = 1'b0;
		i_sample   = '0;
		i_board_in = '0;
		drv_st     = SEED;
		scn_st     = ~SEED;                            // separate scenario stream
		mode       = 0;
		lo_m       = 0;
		hi_m       = 0;
		held       = 1'b0;
		held_data  = '0;
		board_m    = '0;
		ev         = 0;
		repeat (3) @(posedge clk);
		rstn <= 1'b1;

		// version and board inputs
		ask_word(cmd_word(scope_pkg::OP_INFO, 8'd0, 8'd0, 16'd0), w);
		check_equal("info version", 32'd17, w);
		scn_st = lcg_step(scn_st);
		@(posedge clk);
		i_board_in <= scn_st[31:24];
		ask_word(cmd_word(scope_pkg::OP_INFO, 8'd1, 8'd0, 16'd0), w);
		check_equal("info board inputs", {4{scn_st[31:24]}}, w);

		// board output bits
		repeat (8) begin
			scn_st = lcg_step(scn_st);
			b1     = scn_st[31:24];
			b2     = scn_st[23:16];
			board_m[b1[2:0]] = b2[0];
			ask_word(cmd_word(scope_pkg::OP_BOARD, b1, b2, 16'd0), w);
			check_equal("board reply", {24'd0, board_m}, w);
			@(negedge clk);
			check_equal("o_board_out", board_m, o_board_out);
		end

		// thresholds, pre-offset 0, ToT 0
		scn_st = lcg_step(scn_st);
		b1     = 8'd64 + scn_st[31:25];                // level 64 to 191
		b2     = 8'd1 + scn_st[24:20];                 // hysteresis 1 to 32
		lo_m   = thresh_model(int'(b1) - int'(b2));
		hi_m   = thresh_model(int'(b1) + int'(b2));
		ask_word(cmd_word(scope_pkg::OP_TRIG, b1, b2, 16'd0), w);
		check_equal("trig reply", 32'd8, w);

		// immediate capture then readout
		scn_st = lcg_step(scn_st);
		len    = 4 + int'(scn_st[31:16] % 37);
		ask_word(cmd_word(scope_pkg::OP_ARM, scope_pkg::TRIG_NONE, 8'd0, 16'(len)), w);
		t0 = take_idx;                                 // first sample after trigger
		check_equal("arm status", {16'(ev), 16'd0}, w);
		wait_hold(scope_pkg::TRIG_NONE, len, ev + 1);
		ev++;
		run_cmd(cmd_word(scope_pkg::OP_READ, 8'd0, 8'd0, 16'(2 * len)), nw);
		check_equal("read words", (2 * len + 3) / 4, nw);
		rd_run.delete();
		for (int k = 0; k < nw; k++) begin
			r = 2 * len - 4 * k;                       // bytes left
			check_equal("o_tkeep", (r >= 4) ? 32'hf : (32'd1 << r) - 32'd1, rx_keep[k]);
			check_equal("o_tlast", r <= 4, rx_last[k]);
			check_equal("sample padding", 32'd0, rx_data[k] & 32'hf000_f000);
			rd_run.push_back(rx_data[k][11:0]);
			if (r > 2) rd_run.push_back(rx_data[k][27:16]);
		end
		check_equal("readout run end", t0 + len - 1, find_run() + rd_run.size() - 1);

		// rearm after readout, then release again
		scn_st = lcg_step(scn_st);
		len    = 4 + int'(scn_st[31:16] % 37);
		ask_word(cmd_word(scope_pkg::OP_ARM, scope_pkg::TRIG_NONE, 8'd0, 16'(len)), w);
		check_equal("arm status after read", {16'(ev), 16'd0}, w);
		wait_hold(scope_pkg::TRIG_NONE, len, ev + 1);
		ev++;
		run_cmd(cmd_word(scope_pkg::OP_READ, 8'd0, 8'd0, 16'd4), nw);

		// rising threshold
		set_mode(1);
		ask_word(cmd_word(scope_pkg::OP_ARM, scope_pkg::TRIG_RISE, 8'd0, 16'd4), w);
		check_equal("arm status rising", {16'(ev), 16'd0}, w);
		repeat (60) @(posedge clk);                    // no crossing yet
		ask_word(cmd_word(scope_pkg::OP_ARM, scope_pkg::TRIG_RISE, 8'd0, 16'd4), w);
		check_equal("status between thresholds", {16'(ev), 16'd0}, w);
		set_mode(2);
		repeat (4) @(posedge clk);
		set_mode(3);
		repeat (4) @(posedge clk);
		set_mode(1);
		wait_hold(scope_pkg::TRIG_RISE, 4, ev + 1);

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- trigger_fsm.sv
`timescale 1ns/1ps
//----------------------------------------
// acquisition state machine
// writes the ring buffer, detects the
// trigger and counts post samples
//----------------------------------------
module trigger_fsm (
	input  logic                   clk,
	input  logic                   rstn,
	input  scope_pkg::sample_t     i_sample,
	input  scope_pkg::trig_cfg_t   i_cfg,
	input  logic                   i_arm,
	input  logic                   i_readout_done,
	output logic                   o_wr_en,
	output scope_pkg::ram_addr_t   o_wr_addr,
	output scope_pkg::sample_t     o_wr_data,
	output scope_pkg::ram_addr_t   o_trig_addr,
	output scope_pkg::count_t      o_event_count,
	output scope_pkg::count_t      o_post_count
);

	scope_pkg::acq_state_e state;
	scope_pkg::acq_state_e state_nx;
	logic [7:0]            tot_cnt;      // samples past threshold
	logic                  above;
	logic                  below;

	assign above     = (i_sample > i_cfg.upper_th);     // signed compare
	assign below     = (i_sample < i_cfg.lower_th);
	assign o_wr_data = i_sample;                        // written on this edge

	//----------------------------------------
	// next state
	always_comb begin
		state_nx = state;
		case (state)
			scope_pkg::ACQ_READY: begin
				if (i_arm) begin
					if (i_cfg.trig_type == scope_pkg::TRIG_FALL)
						state_nx = scope_pkg::ACQ_FALL_ARM;
					else if (i_cfg.trig_type == scope_pkg::TRIG_RISE)
						state_nx = scope_pkg::ACQ_RISE_ARM;
					else
						state_nx = scope_pkg::ACQ_POST;   // immediate
				end
			end
			scope_pkg::ACQ_FALL_ARM:  if (below) state_nx = scope_pkg::ACQ_FALL_WAIT;
			scope_pkg::ACQ_FALL_WAIT: if (above && tot_cnt >= i_cfg.tot) state_nx = scope_pkg::ACQ_POST;
			scope_pkg::ACQ_RISE_ARM:  if (above) state_nx = scope_pkg::ACQ_RISE_WAIT;
			scope_pkg::ACQ_RISE_WAIT: if (below && tot_cnt >= i_cfg.tot) state_nx = scope_pkg::ACQ_POST;
			scope_pkg::ACQ_POST: begin
				// trigger sample counts as the first one kept
				if (scope_pkg::count_t'(o_post_count + 1'b1) >= i_cfg.post_len)
					state_nx = scope_pkg::ACQ_HOLD;
			end
			scope_pkg::ACQ_HOLD: if (i_readout_done) state_nx = scope_pkg::ACQ_READY;
			default: state_nx = scope_pkg::ACQ_READY;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state         <= scope_pkg::ACQ_READY;
			o_wr_en       <= 1'b0;
			o_wr_addr     <= '0;
			o_trig_addr   <= '0;
			tot_cnt       <= '0;
			o_post_count  <= '0;
			o_event_count <= '0;
		end else begin
			state   <= state_nx;
			o_wr_en <= (state_nx != scope_pkg::ACQ_HOLD);   // frozen while held
			if (o_wr_en) o_wr_addr <= o_wr_addr + 1'b1;
			if (state == scope_pkg::ACQ_READY)
				tot_cnt <= '0;
			else if ((state == scope_pkg::ACQ_FALL_WAIT && above) ||
				(state == scope_pkg::ACQ_RISE_WAIT && below))
				tot_cnt <= tot_cnt + 1'b1;
			// address of the trigger sample
			if (state_nx == scope_pkg::ACQ_POST && state != scope_pkg::ACQ_POST)
				o_trig_addr <= o_wr_addr;
			if (state == scope_pkg::ACQ_HOLD)
				o_post_count <= '1;                       // capture ready
			else if (state == scope_pkg::ACQ_POST || state_nx == scope_pkg::ACQ_POST)
				o_post_count <= o_post_count + 1'b1;
			else
				o_post_count <= '0;
			if (state == scope_pkg::ACQ_POST && state_nx == scope_pkg::ACQ_HOLD)
				o_event_count <= o_event_count + 1'b1;
		end
	end

endmodule
